/* source/vga_cfg.svh */
`ifndef VGA_CFG_SVH
`define VGA_CFG_SVH

// Line timing in pixel clocks
`define VGA_H_TOTAL   976
`define VGA_H_ACTIVE  800
`define VGA_HS_START  840
`define VGA_HS_END    928

// Frame timing in lines
`define VGA_V_TOTAL   528
`define VGA_V_ACTIVE  480
`define VGA_VS_START  493
`define VGA_VS_END    496

// Tiles are 8x8 pixels
`define TILE_SHIFT    3
`define TILE_COLS     100
`define TILE_ROWS     60

`define TILE_ADDR_W   13
`define TILE_COUNT    (`TILE_COLS * `TILE_ROWS)

`endif

/* source/vga_pkg.sv */
`include "vga_cfg.svh"

package vga_pkg;

    typedef struct packed {
        logic red;
        logic green;
        logic blue;
    } color_t;

    typedef enum logic [1:0] {
        OP_CLEAR = 2'd0,
        OP_FILL  = 2'd1,
        OP_FRAME = 2'd2
    } opcode_e;

    typedef enum logic {
        ST_IDLE,
        ST_SWEEP
    } paint_state_e;

    typedef logic [6:0] tile_col_t;   // 0..99
    typedef logic [5:0] tile_row_t;   // 0..59
    typedef logic [`TILE_ADDR_W-1:0] tile_addr_t;

    // Row-major tile index
    function automatic tile_addr_t tile_addr(input tile_row_t row, input tile_col_t col);
        return tile_addr_t'(row) * tile_addr_t'(`TILE_COLS) + tile_addr_t'(col);
    endfunction

endpackage

/* source/tile_bus_if.sv */
`timescale 1ns/1ns

interface tile_bus_if;

    logic                req;
    logic                we;
    vga_pkg::tile_addr_t addr;
    vga_pkg::color_t     wdata;
    logic                gnt;
    vga_pkg::color_t     rdata;   // Valid the cycle after gnt

    modport requester (
        output req,
        output we,
        output addr,
        output wdata,
        input  gnt,
        input  rdata
    );

    modport arbiter (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output gnt,
        output rdata
    );

endinterface

/* source/vga_timing.sv */
`timescale 1ns/1ns
`include "vga_cfg.svh"

module vga_timing (
    input  logic        CLOCK_PIXEL,
    input  logic        RESET,
    output logic [10:0] h_count,
    output logic [9:0]  v_count,
    output logic        active,
    output logic        hs,
    output logic        vs
);

    logic h_last;
    logic v_last;

    assign h_last = (h_count == 11'(`VGA_H_TOTAL - 1));
    assign v_last = (v_count == 10'(`VGA_V_TOTAL - 1));

    always_ff @(posedge CLOCK_PIXEL or posedge RESET) begin
        if (RESET) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_last) begin
            h_count <= '0;
            if (v_last)
                v_count <= '0;   // End of frame
            else
                v_count <= v_count + 10'd1;
        end else begin
            h_count <= h_count + 11'd1;
        end
    end

    assign active = (h_count < 11'(`VGA_H_ACTIVE)) && (v_count < 10'(`VGA_V_ACTIVE));

    // Raw sync levels, positive polarity
    assign hs = (h_count >= 11'(`VGA_HS_START)) && (h_count < 11'(`VGA_HS_END));
    assign vs = (v_count >= 10'(`VGA_VS_START)) && (v_count < 10'(`VGA_VS_END));

endmodule

/* source/pixel_fetch.sv */
`timescale 1ns/1ns
`include "vga_cfg.svh"

module pixel_fetch (
    input  logic         CLOCK_PIXEL,
    input  logic         RESET,
    input  logic [10:0]  h_count,
    input  logic [9:0]   v_count,
    input  logic         active,
    input  logic         hs,
    input  logic         vs,
    tile_bus_if.requester bus,
    output logic         vga_red,
    output logic         vga_green,
    output logic         vga_blue,
    output logic         vga_hs,
    output logic         vga_vs
);

    logic            active_d1;
    logic            active_d2;
    logic            hs_d1;
    logic            hs_d2;
    logic            vs_d1;
    logic            vs_d2;
    vga_pkg::color_t pix_color;

    // Read-only port, one tile lookup per visible pixel
    assign bus.req   = active;
    assign bus.we    = 1'b0;
    assign bus.wdata = '0;
    assign bus.addr  = vga_pkg::tile_addr(v_count[`TILE_SHIFT+5:`TILE_SHIFT],
                                          h_count[`TILE_SHIFT+6:`TILE_SHIFT]);

    always_ff @(posedge CLOCK_PIXEL or posedge RESET) begin
        if (RESET) begin
            active_d1 <= 1'b0;
            active_d2 <= 1'b0;
            hs_d1     <= 1'b0;
            hs_d2     <= 1'b0;
            vs_d1     <= 1'b0;
            vs_d2     <= 1'b0;
        end else begin
            active_d1 <= active;
            active_d2 <= active_d1;
            hs_d1     <= hs;
            hs_d2     <= hs_d1;
            vs_d1     <= vs;
            vs_d2     <= vs_d1;
        end
    end

    always_ff @(posedge CLOCK_PIXEL) begin
        pix_color <= bus.rdata;   // Lines up with active_d2
    end

    assign vga_red   = active_d2 & pix_color.red;
    assign vga_green = active_d2 & pix_color.green;
    assign vga_blue  = active_d2 & pix_color.blue;
    assign vga_hs    = hs_d2;
    assign vga_vs    = vs_d2;

endmodule

/* source/rect_painter.sv */
`timescale 1ns/1ns
`include "vga_cfg.svh"

module rect_painter (
    input  logic               CLOCK_PIXEL,
    input  logic               RESET,
    input  logic               cmd_valid,
    input  vga_pkg::opcode_e   cmd_op,
    input  vga_pkg::tile_col_t cmd_x0,
    input  vga_pkg::tile_row_t cmd_y0,
    input  vga_pkg::tile_col_t cmd_x1,
    input  vga_pkg::tile_row_t cmd_y1,
    input  vga_pkg::color_t    cmd_color,
    output logic               cmd_busy,
    tile_bus_if.requester      bus
);

    vga_pkg::paint_state_e state;
    vga_pkg::opcode_e      op_q;
    vga_pkg::tile_col_t    x0_q;
    vga_pkg::tile_col_t    x1_q;
    vga_pkg::tile_col_t    cur_x;
    vga_pkg::tile_row_t    y0_q;
    vga_pkg::tile_row_t    y1_q;
    vga_pkg::tile_row_t    cur_y;
    vga_pkg::color_t       color_q;
    logic                  accept;
    logic                  step;
    logic                  last_x;
    logic                  last_y;
    logic                  edge_row;

    assign accept   = cmd_valid && (state == vga_pkg::ST_IDLE);
    assign step     = bus.gnt && (state == vga_pkg::ST_SWEEP);   // One tile per grant
    assign last_x   = (cur_x == x1_q);
    assign last_y   = (cur_y == y1_q);
    assign edge_row = (cur_y == y0_q) || (cur_y == y1_q);

    always_ff @(posedge CLOCK_PIXEL or posedge RESET) begin
        if (RESET) begin
            state <= vga_pkg::ST_IDLE;
        end else begin
            case (state)
                vga_pkg::ST_IDLE: begin
                    if (accept)
                        state <= vga_pkg::ST_SWEEP;
                end
                vga_pkg::ST_SWEEP: begin
                    if (step && last_x && last_y)
                        state <= vga_pkg::ST_IDLE;
                end
                default: state <= vga_pkg::ST_IDLE;
            endcase
        end
    end

    // Command latch and cursor
    always_ff @(posedge CLOCK_PIXEL) begin
        if (accept) begin
            op_q <= cmd_op;
            if (cmd_op == vga_pkg::OP_CLEAR) begin
                x0_q    <= '0;
                y0_q    <= '0;
                x1_q    <= vga_pkg::tile_col_t'(`TILE_COLS - 1);
                y1_q    <= vga_pkg::tile_row_t'(`TILE_ROWS - 1);
                cur_x   <= '0;
                cur_y   <= '0;
                color_q <= '0;   // Black
            end else begin
                x0_q    <= cmd_x0;
                y0_q    <= cmd_y0;
                x1_q    <= cmd_x1;
                y1_q    <= cmd_y1;
                cur_x   <= cmd_x0;
                cur_y   <= cmd_y0;
                color_q <= cmd_color;
            end
        end else if (step) begin
            if (last_x) begin
                cur_x <= x0_q;
                cur_y <= cur_y + 1'b1;
            end else if (op_q == vga_pkg::OP_FRAME && !edge_row) begin
                cur_x <= x1_q;   // Jump over the interior
            end else begin
                cur_x <= cur_x + 1'b1;
            end
        end
    end

    assign bus.req   = (state == vga_pkg::ST_SWEEP);
    assign bus.we    = 1'b1;
    assign bus.addr  = vga_pkg::tile_addr(cur_y, cur_x);
    assign bus.wdata = color_q;

    assign cmd_busy = (state == vga_pkg::ST_SWEEP);

endmodule

/* source/tile_store.sv */
`timescale 1ns/1ns
`include "vga_cfg.svh"

module tile_store (
    input  logic        CLOCK_PIXEL,
    tile_bus_if.arbiter fetch,
    tile_bus_if.arbiter paint
);

    vga_pkg::color_t     mem [0:`TILE_COUNT-1];
    vga_pkg::color_t     rdata_q;
    logic                paint_gnt;
    logic                mem_en;
    logic                mem_we;
    vga_pkg::tile_addr_t mem_addr;
    vga_pkg::color_t     mem_wdata;

    // Fixed priority, display always wins
    assign fetch.gnt = fetch.req;
    assign paint_gnt = paint.req && !fetch.req;
    assign paint.gnt = paint_gnt;

    // Single memory port, muxed by grant
    always_comb begin
        if (fetch.req) begin
            mem_en    = 1'b1;
            mem_we    = fetch.we;
            mem_addr  = fetch.addr;
            mem_wdata = fetch.wdata;
        end else begin
            mem_en    = paint_gnt;
            mem_we    = paint.we;
            mem_addr  = paint.addr;
            mem_wdata = paint.wdata;
        end
    end

    always_ff @(posedge CLOCK_PIXEL) begin
        if (mem_en && mem_we)
            mem[mem_addr] <= mem_wdata;
        if (mem_en && !mem_we)
            rdata_q <= mem[mem_addr];   // One-cycle read
    end

    assign fetch.rdata = rdata_q;
    assign paint.rdata = rdata_q;

endmodule

/* source/vga_tile_top.sv */
`timescale 1ns/1ns

module vga_tile_top (
    input  logic               CLOCK_PIXEL,
    input  logic               RESET,
    input  logic               cmd_valid,
    input  vga_pkg::opcode_e   cmd_op,
    input  vga_pkg::tile_col_t cmd_x0,
    input  vga_pkg::tile_row_t cmd_y0,
    input  vga_pkg::tile_col_t cmd_x1,
    input  vga_pkg::tile_row_t cmd_y1,
    input  vga_pkg::color_t    cmd_color,
    output logic               cmd_busy,
    output logic               vga_red,
    output logic               vga_green,
    output logic               vga_blue,
    output logic               vga_hs,
    output logic               vga_vs
);

    logic [10:0] h_count;
    logic [9:0]  v_count;
    logic        active;
    logic        hs;
    logic        vs;

    tile_bus_if fetch_bus ();
    tile_bus_if paint_bus ();

    vga_timing vga_timing_inst (
        .CLOCK_PIXEL (CLOCK_PIXEL),
        .RESET       (RESET),
        .h_count     (h_count),
        .v_count     (v_count),
        .active      (active),
        .hs          (hs),
        .vs          (vs)
    );

    pixel_fetch pixel_fetch_inst (
        .CLOCK_PIXEL (CLOCK_PIXEL),
        .RESET       (RESET),
        .h_count     (h_count),
        .v_count     (v_count),
        .active      (active),
        .hs          (hs),
        .vs          (vs),
        .bus         (fetch_bus.requester),
        .vga_red     (vga_red),
        .vga_green   (vga_green),
        .vga_blue    (vga_blue),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs)
    );

    rect_painter rect_painter_inst (
        .CLOCK_PIXEL (CLOCK_PIXEL),
        .RESET       (RESET),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_x0      (cmd_x0),
        .cmd_y0      (cmd_y0),
        .cmd_x1      (cmd_x1),
        .cmd_y1      (cmd_y1),
        .cmd_color   (cmd_color),
        .cmd_busy    (cmd_busy),
        .bus         (paint_bus.requester)
    );

    tile_store tile_store_inst (
        .CLOCK_PIXEL (CLOCK_PIXEL),
        .fetch       (fetch_bus.arbiter),
        .paint       (paint_bus.arbiter)
    );

endmodule

/* testbench/vga_tile_sva.sv */
`timescale 1ns/1ns
`include "vga_cfg.svh"

module vga_tile_sva (
    input logic                CLOCK_PIXEL,
    input logic                RESET,
    input logic                fetch_req,
    input logic                paint_req,
    input logic                paint_gnt,
    input vga_pkg::tile_addr_t paint_addr,
    input vga_pkg::tile_col_t  last_col,
    input vga_pkg::tile_row_t  last_row,
    input logic                cmd_busy,
    input logic                active,
    input logic                vga_red,
    input logic                vga_green,
    input logic                vga_blue
);

    vga_pkg::tile_addr_t last_addr;
    logic                sweep_last;

    // Bottom-right tile of the latched rectangle ends the sweep
    assign last_addr  = vga_pkg::tile_addr_t'(last_row * `TILE_COLS + last_col);
    assign sweep_last = paint_gnt && (paint_addr == last_addr);

    // Display reads always win, a refused painter keeps its request and address
    paint_priority: assert property (@(posedge CLOCK_PIXEL) disable iff (RESET)
        fetch_req && paint_req |-> !paint_gnt ##1 (paint_req && $stable(paint_addr)))
        else $error("paint_bus granted while fetch_bus requests, or its request moved");

    busy_hold: assert property (@(posedge CLOCK_PIXEL) disable iff (RESET)
        cmd_busy && !sweep_last |=> cmd_busy)
        else $error("cmd_busy fell before the last tile was written");

    blank_black: assert property (@(posedge CLOCK_PIXEL) disable iff (RESET)
        !$past(active, 2) |-> !(vga_red || vga_green || vga_blue))   // Two-cycle latency
        else $error("colour output set outside the active area");

endmodule

bind vga_tile_top vga_tile_sva vga_tile_sva_inst (
    .CLOCK_PIXEL (CLOCK_PIXEL),
    .RESET       (RESET),
    .fetch_req   (fetch_bus.req),
    .paint_req   (paint_bus.req),
    .paint_gnt   (paint_bus.gnt),
    .paint_addr  (paint_bus.addr),
    .last_col    (rect_painter_inst.x1_q),
    .last_row    (rect_painter_inst.y1_q),
    .cmd_busy    (cmd_busy),
    .active      (active),
    .vga_red     (vga_red),
    .vga_green   (vga_green),
    .vga_blue    (vga_blue)
);

/* testbench/vga_tile_tb.sv */
`timescale 1ns/1ns
`include "vga_cfg.svh"

module vga_tile_tb;

    localparam int FRAME_CYCLES = `VGA_H_TOTAL * `VGA_V_TOTAL;
    localparam int WAIT_LIMIT   = 2 * FRAME_CYCLES;

    logic               CLOCK_PIXEL;
    logic               RESET;
    logic               cmd_valid;
    vga_pkg::opcode_e   cmd_op;
    vga_pkg::tile_col_t cmd_x0;
    vga_pkg::tile_row_t cmd_y0;
    vga_pkg::tile_col_t cmd_x1;
    vga_pkg::tile_row_t cmd_y1;
    vga_pkg::color_t    cmd_color;
    logic               cmd_busy;
    logic               vga_red;
    logic               vga_green;
    logic               vga_blue;
    logic               vga_hs;
    logic               vga_vs;

    integer     cyc;            // Cycles since reset release
    integer     value_errors;
    integer     flow_errors;    // Timeouts and file problems
    integer     fd;
    integer     rc;
    integer     f [0:5];
    logic [7:0] tag;
    logic [8*160-1:0] skip_buf;

    vga_tile_top vga_tile_top_inst (.*);

    initial begin
        CLOCK_PIXEL = 1'b0;
        forever #4 CLOCK_PIXEL = ~CLOCK_PIXEL;
    end

    always @(posedge CLOCK_PIXEL or posedge RESET) begin
        if (RESET)
            cyc <= 0;
        else
            cyc <= cyc + 1;
    end

    // Outputs in cycle n+2 belong to pixel n
    function automatic integer pixel_now();
        return (cyc - 2) % FRAME_CYCLES;
    endfunction

    task automatic report_mismatch(input string name, input integer expected, input integer actual);
        $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
        value_errors++;
    endtask

    task automatic wait_idle();
        integer count;
        count = 0;
        while (cmd_busy !== 1'b0 && count < WAIT_LIMIT) begin
            @(negedge CLOCK_PIXEL);
            count++;
        end
        if (cmd_busy !== 1'b0) begin
            $display("Timeout: cmd_busy stayed high for two frames after a command");
            flow_errors++;
        end
    endtask

    task automatic check_sync_frame();
        integer i;
        integer col;
        integer line;
        logic   exp_hs;
        logic   exp_vs;
        for (i = 0; i < FRAME_CYCLES; i++) begin
            @(negedge CLOCK_PIXEL);
            col    = pixel_now() % `VGA_H_TOTAL;
            line   = pixel_now() / `VGA_H_TOTAL;
            exp_hs = (col >= `VGA_HS_START) && (col < `VGA_HS_END);
            exp_vs = (line >= `VGA_VS_START) && (line < `VGA_VS_END);
            if (vga_hs !== exp_hs)
                report_mismatch($sformatf("sync hs at (%0d,%0d)", col, line), exp_hs, vga_hs);
            if (vga_vs !== exp_vs)
                report_mismatch($sformatf("sync vs at (%0d,%0d)", col, line), exp_vs, vga_vs);
            if ((col >= `VGA_H_ACTIVE || line >= `VGA_V_ACTIVE) &&
                {vga_red, vga_green, vga_blue} !== 3'b000)
                report_mismatch($sformatf("blank colour at (%0d,%0d)", col, line), 0,
                                {vga_red, vga_green, vga_blue});
        end
    endtask

    task automatic send_command(input integer op, input integer x0, input integer y0,
                                input integer x1, input integer y1, input integer rgb,
                                input bit while_busy);
        if (!while_busy) begin
            wait_idle();
        end else if (cmd_busy !== 1'b1) begin
            $display("Busy ignore test: cmd_busy was low when the extra command was given");
            flow_errors++;
        end
        cmd_op    = vga_pkg::opcode_e'(op[1:0]);
        cmd_x0    = x0[6:0];
        cmd_y0    = y0[5:0];
        cmd_x1    = x1[6:0];
        cmd_y1    = y1[5:0];
        cmd_color = rgb[2:0];
        cmd_valid = 1'b1;
        @(negedge CLOCK_PIXEL);
        cmd_valid = 1'b0;
        if (!while_busy && cmd_busy !== 1'b1)
            report_mismatch("command accept busy", 1, cmd_busy);
    endtask

    task automatic probe_pixel(input integer col, input integer line, input integer rgb);
        integer target;
        integer count;
        wait_idle();
        target = line * `VGA_H_TOTAL + col;
        count  = 0;
        while (pixel_now() != target && count < WAIT_LIMIT) begin
            @(negedge CLOCK_PIXEL);
            count++;
        end
        if (pixel_now() != target) begin
            $display("Timeout: pixel (%0d,%0d) never came up on the display", col, line);
            flow_errors++;
        end else if ({vga_red, vga_green, vga_blue} !== rgb[2:0]) begin
            report_mismatch($sformatf("probe (%0d,%0d)", col, line), rgb,
                            {vga_red, vga_green, vga_blue});
        end
    endtask

    initial begin
        RESET        = 1'b1;
        cmd_valid    = 1'b0;
        cmd_op       = vga_pkg::OP_CLEAR;
        cmd_x0       = '0;
        cmd_y0       = '0;
        cmd_x1       = '0;
        cmd_y1       = '0;
        cmd_color    = '0;
        value_errors = 0;
        flow_errors  = 0;
        repeat (2) @(posedge CLOCK_PIXEL);
        @(negedge CLOCK_PIXEL);
        if ({cmd_busy, vga_red, vga_green, vga_blue, vga_hs, vga_vs} !== 6'b0)
            report_mismatch("outputs in reset", 0, {cmd_busy, vga_red, vga_green, vga_blue,
                                                    vga_hs, vga_vs});
        RESET = 1'b0;
        @(negedge CLOCK_PIXEL);
        if ({cmd_busy, vga_red, vga_green, vga_blue, vga_hs, vga_vs} !== 6'b0)
            report_mismatch("outputs after release", 0, {cmd_busy, vga_red, vga_green,
                                                         vga_blue, vga_hs, vga_vs});
        check_sync_frame();

        fd = $fopen("testbench/vga_tile_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open testbench/vga_tile_stim.txt");
            flow_errors++;
        end else begin
            while (flow_errors == 0 && $fscanf(fd, " %c", tag) == 1) begin
                case (tag)
                    "#": rc = $fgets(skip_buf, fd);   // Column description
                    "C", "I": begin
                        rc = $fscanf(fd, "%d %d %d %d %d %d", f[0], f[1], f[2], f[3], f[4], f[5]);
                        send_command(f[0], f[1], f[2], f[3], f[4], f[5], tag == "I");
                    end
                    "P": begin
                        rc = $fscanf(fd, "%d %d %d", f[0], f[1], f[2]);
                        probe_pixel(f[0], f[1], f[2]);
                    end
                    default: begin
                        $display("Unknown line type %c in the stimulus file", tag);
                        flow_errors++;
                    end
                endcase
            end
            $fclose(fd);
        end

        $display("Checks done: %0d value errors, %0d other errors", value_errors, flow_errors);
        if (value_errors == 0 && flow_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* testbench/vga_tile_stim.txt */
# C|I op x0 y0 x1 y1 rgb : command (op 0 clear, 1 fill, 2 frame), I is given while busy
# P column line rgb : expected colour bits red,green,blue at that pixel
C 0 0 0 0 0 5
P 0 0 0
P 900 100 0
P 799 479 0
P 10 500 0
C 1 10 5 20 12 2
P 80 40 2
P 79 40 0
P 167 103 2
P 168 103 0
C 1 30 20 40 30 1
C 2 30 20 40 30 4
P 240 160 4
P 280 200 1
P 327 200 4
P 280 247 4
C 1 60 40 70 50 7
I 1 80 50 90 55 6
P 480 320 7
P 640 400 0
P 567 407 7

/* vlog.f */
+incdir+source
source/vga_pkg.sv
source/tile_bus_if.sv
source/vga_timing.sv
source/pixel_fetch.sv
source/rect_painter.sv
source/tile_store.sv
source/vga_tile_top.sv
testbench/vga_tile_sva.sv
testbench/vga_tile_tb.sv
